/* list.f */
+incdir+tb
source/udp_pkg.sv
source/eth_crc32.sv
source/arp_resolver.sv
source/udp_packet_builder.sv
source/mac_tx_arbiter.sv
source/udp_sender.sv
tb/udp_sender_tb.sv

/* run.sh */
#!/usr/bin/env bash
rm -f sim.log \
    && verilator --binary --timing --assert -j 0 -f list.f \
        --top-module udp_sender_tb -o udp_sender_sim \
    && ./obj_dir/udp_sender_sim | tee sim.log \
    && grep -q "^Verification passed$" sim.log \
    || { echo "Simulation did not pass, see sim.log"; exit 1; }

/* source/arp_resolver.sv */
module arp_resolver
    import udp_pkg::*;
(
    input  logic      rgmii_clk,
    input  logic      rstn,
    input  logic      rx_valid,
    input  byte_t     rx_data,
    input  logic      arp_rd,
    output logic      arp_req,
    output byte_t     arp_byte,
    output logic      arp_last,
    output mac_addr_t dest_mac,
    output logic      arp_found
);

    arp_state_t  state;
    logic [5:0]  tx_idx;
    logic [16:0] retry_cnt;
    logic [5:0]  rx_idx;
    logic        rx_bad;
    logic        chk;
    byte_t       exp_byte;
    mac_addr_t   sha;
    logic        frame_ok;

    assign arp_req   = (state == ARP_SEND);
    assign arp_found = (state == ARP_FOUND);
    assign arp_last  = (tx_idx == 6'(ARP_FRAME_LEN - 1));

    // Broadcast request, target hardware address left at zero.
    always_comb begin
        arp_byte = 8'h00;
        case (tx_idx) inside
            [6'd0:6'd5]:   arp_byte = mac_byte(BCAST_MAC, int'(tx_idx));
            [6'd6:6'd11]:  arp_byte = mac_byte(LOCAL_MAC, int'(tx_idx) - 6);
            6'd12:         arp_byte = ETH_TYPE_ARP[15:8];
            6'd13:         arp_byte = ETH_TYPE_ARP[7:0];
            6'd15:         arp_byte = 8'h01;
            6'd16:         arp_byte = ETH_TYPE_IP[15:8];
            6'd17:         arp_byte = ETH_TYPE_IP[7:0];
            6'd18:         arp_byte = 8'h06;
            6'd19:         arp_byte = 8'h04;
            6'd21:         arp_byte = ARP_OP_REQUEST;
            [6'd22:6'd27]: arp_byte = mac_byte(LOCAL_MAC, int'(tx_idx) - 22);
            [6'd28:6'd31]: arp_byte = ip_byte(LOCAL_IP, int'(tx_idx) - 28);
            [6'd38:6'd41]: arp_byte = ip_byte(DEST_IP, int'(tx_idx) - 38);
            default:       arp_byte = 8'h00;
        endcase
    end

    always_ff @(posedge rgmii_clk) begin
        if (!rstn) begin
            state     <= ARP_IDLE;
            tx_idx    <= '0;
            retry_cnt <= '0;
        end else begin
            case (state)
                ARP_IDLE: state <= ARP_SEND;
                ARP_SEND: begin
                    if (arp_rd) begin
                        if (arp_last) begin
                            tx_idx    <= '0;
                            retry_cnt <= '0;
                            state     <= ARP_WAIT;
                        end else begin
                            tx_idx <= tx_idx + 6'd1;
                        end
                    end
                end
                ARP_WAIT: begin
                    if (frame_ok) begin
                        state <= ARP_FOUND;
                    end else if (retry_cnt == 17'(ARP_RETRY_CYCLES - 1)) begin
                        state <= ARP_SEND;
                    end else begin
                        retry_cnt <= retry_cnt + 17'd1;
                    end
                end
                ARP_FOUND: state <= ARP_FOUND;
                default:   state <= ARP_IDLE;
            endcase
        end
    end

    // Only these positions decide whether a frame is the reply we want.
    always_comb begin
        chk      = 1'b1;
        exp_byte = 8'h00;
        case (rx_idx) inside
            6'd12:         exp_byte = ETH_TYPE_ARP[15:8];
            6'd13:         exp_byte = ETH_TYPE_ARP[7:0];
            6'd20:         exp_byte = 8'h00;
            6'd21:         exp_byte = ARP_OP_REPLY;
            [6'd28:6'd31]: exp_byte = ip_byte(DEST_IP, int'(rx_idx) - 28);
            [6'd38:6'd41]: exp_byte = ip_byte(LOCAL_IP, int'(rx_idx) - 38);
            default:       chk = 1'b0;
        endcase
    end

    always_ff @(posedge rgmii_clk) begin
        if (!rstn) begin
            rx_idx <= '0;
            rx_bad <= 1'b0;
        end else if (rx_valid) begin
            if (rx_idx != 6'd63) begin
                rx_idx <= rx_idx + 6'd1;
            end
            if (chk && rx_data != exp_byte) begin
                rx_bad <= 1'b1;
            end
        end else begin
            rx_idx <= '0;
            rx_bad <= 1'b0;
        end
    end

    // A nonzero index with rx_valid low marks the cycle right after a frame.
    assign frame_ok = !rx_valid && !rx_bad && (rx_idx >= 6'(ARP_CONTENT_LEN));

    always_ff @(posedge rgmii_clk) begin
        if (rx_valid && rx_idx >= 6'd22 && rx_idx <= 6'd27) begin
            sha <= {sha[39:0], rx_data};
        end
        if (state == ARP_WAIT && frame_ok) begin
            dest_mac <= sha;
        end
    end

    a_rd_needs_req: assert property (@(posedge rgmii_clk) disable iff (!rstn)
        arp_rd |-> arp_req);

endmodule : arp_resolver

/* source/eth_crc32.sv */
module eth_crc32
    import udp_pkg::*;
(
    input  logic  rgmii_clk,
    input  logic  rstn,
    input  logic  clear,
    input  logic  update,
    input  byte_t din,
    output crc_t  crc
);

    crc_t crc_reg;

    // Bits enter LSB first, so the reflected polynomial shifts right.
    function automatic crc_t crc_step(crc_t c, byte_t d);
        crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ CRC_POLY_REFL;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge rgmii_clk) begin
        if (!rstn || clear) begin
            crc_reg <= '1;
        end else if (update) begin
            crc_reg <= crc_step(crc_reg, din);
        end
    end

    assign crc = ~crc_reg;

endmodule : eth_crc32

/* source/mac_tx_arbiter.sv */
module mac_tx_arbiter
    import udp_pkg::*;
(
    input  logic  rgmii_clk,
    input  logic  rstn,
    input  logic  arp_req,
    input  byte_t arp_byte,
    input  logic  arp_last,
    input  logic  udp_req,
    input  byte_t udp_byte,
    input  logic  udp_last,
    output logic  arp_rd,
    output logic  udp_rd,
    output logic  tx_valid,
    output byte_t tx_data
);

    tx_state_t  state;
    logic [3:0] cnt;
    logic       sel_arp;
    logic       shown_last;
    logic       rd;
    logic       crc_clear;
    byte_t      src_byte;
    logic       src_last;
    crc_t       crc;
    crc_t       fcs_sr;

    assign src_byte  = sel_arp ? arp_byte : udp_byte;
    assign src_last  = sel_arp ? arp_last : udp_last;
    assign crc_clear = (state == TX_IDLE);

    // The source byte is taken one cycle before it appears on tx_data.
    assign rd     = (state == TX_PREAMBLE && cnt == 4'd7) || (state == TX_DATA && !shown_last);
    assign arp_rd = rd && sel_arp;
    assign udp_rd = rd && !sel_arp;

    eth_crc32 crc_i (
        .rgmii_clk (rgmii_clk),
        .rstn      (rstn),
        .clear     (crc_clear),
        .update    (rd),
        .din       (src_byte),
        .crc       (crc)
    );

    always_ff @(posedge rgmii_clk) begin
        if (!rstn) begin
            state      <= TX_IDLE;
            cnt        <= '0;
            sel_arp    <= 1'b0;
            shown_last <= 1'b0;
            tx_valid   <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (arp_req || udp_req) begin
                        sel_arp  <= arp_req;
                        cnt      <= '0;
                        tx_valid <= 1'b1;
                        state    <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd7) begin
                        shown_last <= src_last;
                        state      <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (shown_last) begin
                        cnt   <= '0;
                        state <= TX_FCS;
                    end else begin
                        shown_last <= src_last;
                    end
                end
                TX_FCS: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd3) begin
                        cnt      <= '0;
                        tx_valid <= 1'b0;
                        state    <= TX_GAP;
                    end
                end
                TX_GAP: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'(IFG_CYCLES - 1)) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (rd) begin
            tx_data <= src_byte;
        end else begin
            case (state)
                TX_PREAMBLE: tx_data <= (cnt == 4'd6) ? SFD_BYTE : PREAMBLE_BYTE;
                TX_DATA: begin
                    tx_data <= crc[7:0];
                    fcs_sr  <= crc >> 8;
                end
                TX_FCS: begin
                    tx_data <= fcs_sr[7:0];
                    fcs_sr  <= fcs_sr >> 8;
                end
                default: tx_data <= PREAMBLE_BYTE;
            endcase
        end
    end

    a_gap_idle: assert property (@(posedge rgmii_clk) disable iff (!rstn)
        state == TX_GAP |-> !tx_valid);

endmodule : mac_tx_arbiter

/* source/udp_packet_builder.sv */
module udp_packet_builder
    import udp_pkg::*;
(
    input  logic      rgmii_clk,
    input  logic      rstn,
    input  logic      trig,
    input  byte_t     data,
    input  logic      arp_found,
    input  mac_addr_t dest_mac,
    input  logic      udp_rd,
    output logic      udp_req,
    output byte_t     udp_byte,
    output logic      udp_last
);

    byte_t       bank [2][PAYLOAD_LEN];
    logic [1:0]  full;
    logic        wr_bank;
    logic [4:0]  wr_idx;
    logic        rd_bank;
    logic [5:0]  out_idx;
    logic [4:0]  pay_idx;
    len16_t      ident;
    len16_t      ip_csum;
    logic        accept;
    logic        start;
    logic [19:0] hdr_sum;
    logic [16:0] fold_sum;
    len16_t      hdr_csum;

    assign accept   = trig && !full[wr_bank];
    assign start    = !udp_req && full[rd_bank] && arp_found;
    assign udp_last = (out_idx == 6'(UDP_FRAME_LEN - 1));
    assign pay_idx  = 5'(out_idx - 6'(PAYLOAD_OFS));

    // Ones'-complement sum over the header words with the checksum field at zero.
    assign hdr_sum = 20'({IP_VER_IHL, 8'h00}) + 20'(IP_TOTAL_LEN) + 20'(ident)
                   + 20'(IP_FLAGS) + 20'({IP_TTL, IP_PROTO_UDP})
                   + 20'(LOCAL_IP[31:16]) + 20'(LOCAL_IP[15:0])
                   + 20'(DEST_IP[31:16]) + 20'(DEST_IP[15:0]);
    assign fold_sum = 17'(hdr_sum[15:0]) + 17'(hdr_sum[19:16]);
    assign hdr_csum = ~(fold_sum[15:0] + 16'(fold_sum[16]));

    always_ff @(posedge rgmii_clk) begin
        if (!rstn) begin
            full    <= '0;
            wr_bank <= 1'b0;
            wr_idx  <= '0;
            rd_bank <= 1'b0;
            out_idx <= '0;
            udp_req <= 1'b0;
            ident   <= '0;
        end else begin
            if (accept) begin
                if (wr_idx == 5'(PAYLOAD_LEN - 1)) begin
                    wr_idx        <= '0;
                    full[wr_bank] <= 1'b1;
                    wr_bank       <= !wr_bank;
                end else begin
                    wr_idx <= wr_idx + 5'd1;
                end
            end
            if (start) begin
                udp_req <= 1'b1;
            end
            if (udp_rd) begin
                if (udp_last) begin
                    out_idx       <= '0;
                    udp_req       <= 1'b0;
                    full[rd_bank] <= 1'b0;
                    rd_bank       <= !rd_bank;
                    ident         <= ident + 16'd1;
                end else begin
                    out_idx <= out_idx + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (accept) begin
            bank[wr_bank][wr_idx] <= data;
        end
        if (start) begin
            ip_csum <= hdr_csum;
        end
    end

    always_comb begin
        udp_byte = 8'h00;
        case (out_idx) inside
            [6'd0:6'd5]:   udp_byte = mac_byte(dest_mac, int'(out_idx));
            [6'd6:6'd11]:  udp_byte = mac_byte(LOCAL_MAC, int'(out_idx) - 6);
            6'd12:         udp_byte = ETH_TYPE_IP[15:8];
            6'd13:         udp_byte = ETH_TYPE_IP[7:0];
            6'd14:         udp_byte = IP_VER_IHL;
            6'd16:         udp_byte = IP_TOTAL_LEN[15:8];
            6'd17:         udp_byte = IP_TOTAL_LEN[7:0];
            6'd18:         udp_byte = ident[15:8];
            6'd19:         udp_byte = ident[7:0];
            6'd20:         udp_byte = IP_FLAGS[15:8];
            6'd21:         udp_byte = IP_FLAGS[7:0];
            6'd22:         udp_byte = IP_TTL;
            6'd23:         udp_byte = IP_PROTO_UDP;
            6'd24:         udp_byte = ip_csum[15:8];
            6'd25:         udp_byte = ip_csum[7:0];
            [6'd26:6'd29]: udp_byte = ip_byte(LOCAL_IP, int'(out_idx) - 26);
            [6'd30:6'd33]: udp_byte = ip_byte(DEST_IP, int'(out_idx) - 30);
            6'd34:         udp_byte = LOCAL_PORT[15:8];
            6'd35:         udp_byte = LOCAL_PORT[7:0];
            6'd36:         udp_byte = DEST_PORT[15:8];
            6'd37:         udp_byte = DEST_PORT[7:0];
            6'd38:         udp_byte = UDP_LEN[15:8];
            6'd39:         udp_byte = UDP_LEN[7:0];
            [6'd42:6'd59]: udp_byte = bank[rd_bank][pay_idx];
            default:       udp_byte = 8'h00;
        endcase
    end

    a_req_after_arp: assert property (@(posedge rgmii_clk) disable iff (!rstn)
        $rose(udp_req) |-> arp_found);

endmodule : udp_packet_builder

/* source/udp_pkg.sv */
package udp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;
    typedef logic [31:0] crc_t;

    localparam mac_addr_t LOCAL_MAC  = 48'h11_11_11_11_11_11;
    localparam ip_addr_t  LOCAL_IP   = 32'hC0_A8_01_6E;
    localparam port_t     LOCAL_PORT = 16'h8080;
    localparam ip_addr_t  DEST_IP    = 32'hC0_A8_01_69;
    localparam port_t     DEST_PORT  = 16'h8080;
    localparam mac_addr_t BCAST_MAC  = 48'hFF_FF_FF_FF_FF_FF;

    // Payload length is fixed, so a UDP frame is exactly the 60-byte minimum.
    localparam int      PAYLOAD_LEN   = 18;
    localparam int      ETH_HDR_LEN   = 14;
    localparam int      IP_HDR_LEN    = 20;
    localparam int      UDP_HDR_LEN   = 8;
    localparam int      PAYLOAD_OFS   = ETH_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN;
    localparam int      UDP_FRAME_LEN = PAYLOAD_OFS + PAYLOAD_LEN;
    localparam len16_t  IP_TOTAL_LEN  = len16_t'(IP_HDR_LEN + UDP_HDR_LEN + PAYLOAD_LEN);
    localparam len16_t  UDP_LEN       = len16_t'(UDP_HDR_LEN + PAYLOAD_LEN);

    localparam int      ARP_FRAME_LEN    = 60;
    localparam int      ARP_CONTENT_LEN  = 42;
    localparam int      ARP_RETRY_CYCLES = 125_000;
    localparam int      IFG_CYCLES       = 12;

    localparam byte_t   IP_VER_IHL    = 8'h45;
    localparam byte_t   IP_TTL        = 8'd64;
    localparam byte_t   IP_PROTO_UDP  = 8'd17;
    localparam len16_t  IP_FLAGS      = 16'h4000;
    localparam len16_t  ETH_TYPE_IP   = 16'h0800;
    localparam len16_t  ETH_TYPE_ARP  = 16'h0806;
    localparam byte_t   ARP_OP_REQUEST = 8'd1;
    localparam byte_t   ARP_OP_REPLY   = 8'd2;

    localparam crc_t    CRC_POLY_REFL = 32'hEDB8_8320;
    localparam byte_t   PREAMBLE_BYTE = 8'h55;
    localparam byte_t   SFD_BYTE      = 8'hD5;

    typedef enum logic [1:0] {ARP_IDLE, ARP_SEND, ARP_WAIT, ARP_FOUND} arp_state_t;
    typedef enum logic [2:0] {TX_IDLE, TX_PREAMBLE, TX_DATA, TX_FCS, TX_GAP} tx_state_t;

    // Byte k of an address, counted from the most significant byte as it goes on the wire.
    function automatic byte_t mac_byte(mac_addr_t mac, int k);
        return mac[47 - 8 * k -: 8];
    endfunction

    function automatic byte_t ip_byte(ip_addr_t ip, int k);
        return ip[31 - 8 * k -: 8];
    endfunction

endpackage : udp_pkg

/* source/udp_sender.sv */
module udp_sender
    import udp_pkg::*;
(
    input  logic  rgmii_clk,
    input  logic  rstn,
    input  logic  trig,
    input  byte_t data,
    output logic  connected,
    input  logic  rx_valid,
    input  byte_t rx_data,
    output logic  tx_valid,
    output byte_t tx_data
);

    logic      arp_req;
    byte_t     arp_byte;
    logic      arp_last;
    logic      arp_rd;
    logic      udp_req;
    byte_t     udp_byte;
    logic      udp_last;
    logic      udp_rd;
    mac_addr_t dest_mac;
    logic      arp_found;

    assign connected = arp_found;

    arp_resolver arp_i (
        .rgmii_clk (rgmii_clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .arp_rd    (arp_rd),
        .arp_req   (arp_req),
        .arp_byte  (arp_byte),
        .arp_last  (arp_last),
        .dest_mac  (dest_mac),
        .arp_found (arp_found)
    );

    udp_packet_builder udp_i (
        .rgmii_clk (rgmii_clk),
        .rstn      (rstn),
        .trig      (trig),
        .data      (data),
        .arp_found (arp_found),
        .dest_mac  (dest_mac),
        .udp_rd    (udp_rd),
        .udp_req   (udp_req),
        .udp_byte  (udp_byte),
        .udp_last  (udp_last)
    );

    mac_tx_arbiter mac_i (
        .rgmii_clk (rgmii_clk),
        .rstn      (rstn),
        .arp_req   (arp_req),
        .arp_byte  (arp_byte),
        .arp_last  (arp_last),
        .udp_req   (udp_req),
        .udp_byte  (udp_byte),
        .udp_last  (udp_last),
        .arp_rd    (arp_rd),
        .udp_rd    (udp_rd),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data)
    );

endmodule : udp_sender

/* tb/udp_sender_tb_model.svh */
`ifndef UDP_SENDER_TB_MODEL_SVH
`define UDP_SENDER_TB_MODEL_SVH

// Model frame buffer, holding the 60 bytes between SFD and FCS.
byte_t frame_buf [60];
byte_t payload_q [$];

function automatic void put_field(int pos, logic [47:0] v, int n);
    for (int i = 0; i < n; i++) begin
        frame_buf[pos + i] = v[8 * (n - 1 - i) +: 8];
    end
endfunction

function automatic void clear_frame();
    for (int i = 0; i < 60; i++) begin
        frame_buf[i] = 8'h00;
    end
endfunction

// MSB-first CRC-32 fed with the bits of each byte LSB first, then bit-reversed.
function automatic crc_t ref_fcs(int n);
    crc_t c;
    crc_t r;
    logic fb;
    c = 32'hFFFF_FFFF;
    for (int k = 0; k < n; k++) begin
        for (int i = 0; i < 8; i++) begin
            fb = c[31] ^ frame_buf[k][i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ 32'h04C1_1DB7;
            end
        end
    end
    for (int i = 0; i < 32; i++) begin
        r[i] = c[31 - i];
    end
    return ~r;
endfunction

function automatic len16_t ref_ip_csum();
    logic [31:0] sum;
    sum = 32'h0;
    for (int k = 14; k < 34; k += 2) begin
        sum = sum + {16'h0000, frame_buf[k], frame_buf[k + 1]};
    end
    while (sum[31:16] != 16'h0000) begin
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    end
    return ~sum[15:0];
endfunction

function automatic void build_arp_request();
    clear_frame();
    put_field(0, 48'hFFFF_FFFF_FFFF, 6);
    put_field(6, LOCAL_MAC, 6);
    put_field(12, 48'h0806, 2);
    put_field(14, 48'h0001_0800_0604, 6);
    put_field(20, 48'h0001, 2);
    put_field(22, LOCAL_MAC, 6);
    put_field(28, 48'(LOCAL_IP), 4);
    put_field(38, 48'(DEST_IP), 4);
endfunction

function automatic void build_arp_reply(mac_addr_t sha, ip_addr_t spa);
    clear_frame();
    put_field(0, LOCAL_MAC, 6);
    put_field(6, sha, 6);
    put_field(12, 48'h0806, 2);
    put_field(14, 48'h0001_0800_0604, 6);
    put_field(20, 48'h0002, 2);
    put_field(22, sha, 6);
    put_field(28, 48'(spa), 4);
    put_field(32, LOCAL_MAC, 6);
    put_field(38, 48'(LOCAL_IP), 4);
endfunction

function automatic void build_udp(mac_addr_t dmac, len16_t id);
    clear_frame();
    put_field(0, dmac, 6);
    put_field(6, LOCAL_MAC, 6);
    put_field(12, 48'h0800, 2);
    put_field(14, 48'h4500, 2);
    put_field(16, 48'(20 + 8 + PAYLOAD_LEN), 2);
    put_field(18, 48'(id), 2);
    // Don't-fragment set, offset zero.
    put_field(20, 48'h4000, 2);
    put_field(22, 48'h4011, 2);
    put_field(26, 48'(LOCAL_IP), 4);
    put_field(30, 48'(DEST_IP), 4);
    put_field(34, 48'(LOCAL_PORT), 2);
    put_field(36, 48'(DEST_PORT), 2);
    put_field(38, 48'(8 + PAYLOAD_LEN), 2);
    for (int i = 0; i < PAYLOAD_LEN; i++) begin
        frame_buf[42 + i] = payload_q.pop_front();
    end
    put_field(24, 48'(ref_ip_csum()), 2);
endfunction

task automatic compare_byte(byte_t got, byte_t exp, string what);
    if (got !== exp) begin
        errors++;
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_mac(mac_addr_t got, mac_addr_t exp, string what);
    if (got !== exp) begin
        errors++;
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_crc(crc_t got, crc_t exp, string what);
    if (got !== exp) begin
        errors++;
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_flag(logic got, logic exp, string what);
    if (got !== exp) begin
        errors++;
        $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

/* tb/udp_sender_tb.sv */
module udp_sender_tb
    import udp_pkg::*;
();

    localparam int FRAME_CYCLES    = 72;
    localparam int TEST_FRAMES     = 5;
    localparam int WATCHDOG_CYCLES = 3 * ARP_RETRY_CYCLES + 2000 * TEST_FRAMES;
    localparam mac_addr_t PEER_MAC = 48'h02_5E_10_20_30_40;

    logic  rgmii_clk;
    logic  rstn;
    logic  trig;
    byte_t data;
    logic  connected;
    logic  rx_valid;
    byte_t rx_data;
    logic  tx_valid;
    byte_t tx_data;

    int    errors = 0;
    int    cycle = 0;
    int    run_len = 0;
    logic  tx_prev = 1'b0;
    byte_t cap_bytes [$];
    int    cap_len [$];
    int    cap_start [$];
    int    cap_end [$];
    byte_t got [128];
    int    got_len;
    int    got_start;
    int    got_end;
    int    arp_start;
    len16_t next_ident = 16'h0000;

    `include "udp_sender_tb_model.svh"

    udp_sender dut_i (
        .rgmii_clk (rgmii_clk),
        .rstn      (rstn),
        .trig      (trig),
        .data      (data),
        .connected (connected),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data)
    );

    always #50 rgmii_clk = ~rgmii_clk;

    // Frames are captured at the falling edge, where tx_valid and tx_data are settled.
    always @(negedge rgmii_clk) begin
        if (tx_valid === 1'b1) begin
            if (tx_prev !== 1'b1) begin
                cap_start.push_back(cycle);
                run_len = 0;
            end
            cap_bytes.push_back(tx_data);
            run_len++;
        end else if (tx_prev === 1'b1) begin
            cap_len.push_back(run_len);
            cap_end.push_back(cycle);
        end
        tx_prev = tx_valid;
        cycle++;
    end

    task automatic take_frame(string what, int limit, output logic ok);
        int    waited;
        byte_t b;
        waited = 0;
        while (cap_len.size() == 0 && waited < limit) begin
            @(posedge rgmii_clk);
            waited++;
        end
        ok = (cap_len.size() != 0);
        if (!ok) begin
            errors++;
            $display("No %s frame appeared on tx within %0d cycles", what, limit);
            return;
        end
        got_len   = cap_len.pop_front();
        got_start = cap_start.pop_front();
        got_end   = cap_end.pop_front();
        for (int i = 0; i < got_len; i++) begin
            b = cap_bytes.pop_front();
            if (i < 128) begin
                got[i] = b;
            end
        end
    endtask

    task automatic check_frame(string what);
        crc_t fcs_got;
        if (got_len != FRAME_CYCLES) begin
            errors++;
            $display("Fail %0t: %s frame is %0d cycles long, expected %0d",
                     $time, what, got_len, FRAME_CYCLES);
            return;
        end
        for (int i = 0; i < 7; i++) begin
            compare_byte(got[i], 8'h55, $sformatf("%s preamble byte %0d", what, i));
        end
        compare_byte(got[7], 8'hD5, {what, " SFD"});
        for (int i = 0; i < 60; i++) begin
            compare_byte(got[8 + i], frame_buf[i], $sformatf("%s byte %0d", what, i));
        end
        // FCS goes out least significant byte first.
        fcs_got = {got[71], got[70], got[69], got[68]};
        compare_crc(fcs_got, ref_fcs(60), {what, " FCS"});
    endtask

    task automatic send_arp_reply(mac_addr_t sha, ip_addr_t spa);
        build_arp_reply(sha, spa);
        for (int i = 0; i < 60; i++) begin
            @(posedge rgmii_clk);
            rx_valid <= 1'b1;
            rx_data  <= frame_buf[i];
        end
        @(posedge rgmii_clk);
        rx_valid <= 1'b0;
        rx_data  <= 8'h00;
    endtask

    task automatic send_payload(int n);
        byte_t b;
        for (int i = 0; i < n; i++) begin
            b = byte_t'($urandom);
            payload_q.push_back(b);
            @(posedge rgmii_clk);
            trig <= 1'b1;
            data <= b;
        end
        @(posedge rgmii_clk);
        trig <= 1'b0;
    endtask

    task automatic test_first_arp();
        logic ok;
        @(negedge rgmii_clk);
        compare_flag(connected, 1'b0, "connected after reset");
        take_frame("first ARP", 4000, ok);
        if (ok) begin
            build_arp_request();
            check_frame("ARP request");
            arp_start = got_start;
        end
    endtask

    task automatic test_arp_retry();
        logic ok;
        take_frame("repeated ARP", ARP_RETRY_CYCLES + 2000, ok);
        if (ok) begin
            build_arp_request();
            check_frame("ARP retry");
            if (got_start - arp_start < ARP_RETRY_CYCLES) begin
                errors++;
                $display("Fail %0t: ARP retry started %0d cycles after the first, expected %0d",
                         $time, got_start - arp_start, ARP_RETRY_CYCLES);
            end
        end
        // One address byte off, so the reply must be ignored.
        send_arp_reply(PEER_MAC, DEST_IP ^ 32'h0000_0003);
        repeat (4) @(negedge rgmii_clk);
        compare_flag(connected, 1'b0, "connected after a reply from the wrong IP");
    endtask

    task automatic test_arp_reply();
        int waited;
        send_arp_reply(PEER_MAC, DEST_IP);
        waited = 0;
        while (connected !== 1'b1 && waited < 20) begin
            @(negedge rgmii_clk);
            waited++;
        end
        compare_flag(connected, 1'b1, "connected after the matching reply");
    endtask

    task automatic test_single_datagram();
        logic ok;
        send_payload(PAYLOAD_LEN);
        build_udp(PEER_MAC, next_ident);
        take_frame("UDP", 2000, ok);
        if (ok) begin
            check_frame("UDP");
            compare_mac({got[8], got[9], got[10], got[11], got[12], got[13]}, PEER_MAC,
                        "UDP destination MAC");
        end
        next_ident++;
    endtask

    task automatic test_two_datagrams();
        logic ok_a;
        logic ok_b;
        int   first_end;
        first_end = 0;
        send_payload(2 * PAYLOAD_LEN);
        build_udp(PEER_MAC, next_ident);
        take_frame("first of two UDP", 2000, ok_a);
        if (ok_a) begin
            check_frame("UDP n");
            first_end = got_end;
        end
        next_ident++;
        build_udp(PEER_MAC, next_ident);
        take_frame("second of two UDP", 2000, ok_b);
        if (ok_b) begin
            check_frame("UDP n+1");
        end
        if (ok_a && ok_b && got_start - first_end < IFG_CYCLES) begin
            errors++;
            $display("Fail %0t: gap between frames is %0d cycles, expected at least %0d",
                     $time, got_start - first_end, IFG_CYCLES);
        end
        next_ident++;
    endtask

    initial begin
        void'($urandom(32'h15ca_4975));
        rgmii_clk = 1'b0;
        rstn      = 1'b0;
        trig      = 1'b0;
        data      = 8'h00;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        repeat (5) @(posedge rgmii_clk);
        rstn <= 1'b1;
        test_first_arp();
        test_arp_retry();
        test_arp_reply();
        test_single_datagram();
        test_two_datagrams();
        repeat (20) @(posedge rgmii_clk);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge rgmii_clk);
        $display("Watchdog expired after %0d cycles with %0d errors so far",
                 WATCHDOG_CYCLES, errors);
        $display("Verification failed");
        $finish;
    end

endmodule : udp_sender_tb
